// ==== source/ps2_pkg.sv ====
package ps2_pkg;

	////////////////////////////////////////
	// Frame format
	////////////////////////////////////////

	// Start, 8 data bits LSB first, odd parity, stop
	localparam int PS2_FRAME_BITS = 11;

	typedef logic [7:0] ps2_byte_t;

	// Shifted in from the top so the start bit ends up in bit 0
	typedef logic [PS2_FRAME_BITS-1:0] ps2_frame_t;

	// 0 is the keyboard and 1 the mouse
	typedef logic [0:0] ps2_port_t;

	// Entry holds the port in bit 9, err in bit 8 and the byte below
	typedef logic [9:0] ps2_entry_t;

	////////////////////////////////////////
	// Reader FSM
	////////////////////////////////////////

	typedef enum logic [1:0] {
		st_idle,
		st_read,
		st_end,
		st_hold
	} ps2_read_state_t;

endpackage

// ==== source/ps2_frame_if.sv ====
`timescale 1ns/1ps

interface ps2_frame_if;
	import ps2_pkg::*;

	// Reader holds these stable while pending is high
	logic      pending;
	ps2_byte_t entry_byte;
	logic      err;

	// One-cycle pulse after which the reader drops pending
	logic      grant;

	modport reader (
		output pending, entry_byte, err,
		input  grant
	);

	modport arbiter (
		input  pending, entry_byte, err,
		output grant
	);

endinterface

// ==== source/ps2_tick_gen.sv ====
`timescale 1ns/1ps

module ps2_tick_gen #(
	parameter int CLK_PER_US = 125
) (
	input  logic clk_main_loop,
	input  logic rst_n,
	output logic us_tick
);

	localparam int CNT_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;

	logic [CNT_W-1:0] cnt;

	// Wrapping down-counter that strobes on the reload cycle
	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			cnt     <= CNT_W'(CLK_PER_US - 1);
			us_tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt     <= CNT_W'(CLK_PER_US - 1);
			us_tick <= 1'b1;
		end else begin
			cnt     <= cnt - 1'b1;
			us_tick <= 1'b0;
		end
	end

endmodule

// ==== source/ps2_read.sv ====
`timescale 1ns/1ps

module ps2_read #(
	parameter int TIMEOUT_US = 2000,
	parameter int IDLE_US    = 100
) (
	input  logic        clk_main_loop,
	input  logic        rst_n,
	input  logic        us_tick,
	input  logic        enable,
	input  logic        ps2c,
	input  logic        ps2d,
	output logic        reading,
	ps2_frame_if.reader frame
);
	import ps2_pkg::*;

	// One timer serves both the frame timeout and the idle wait
	localparam int US_MAX = (TIMEOUT_US > IDLE_US) ? TIMEOUT_US : IDLE_US;
	localparam int US_W   = $clog2(US_MAX + 1);
	localparam logic [3:0] LAST_BIT = 4'(PS2_FRAME_BITS - 1);

	logic [1:0]      ps2c_sync;
	logic [1:0]      ps2d_sync;
	logic            ps2c_old;
	logic            fall_edge;
	logic            lines_idle;
	logic            shift_en;
	logic            timeout_hit;
	logic            done_idle;
	logic            frame_err;
	ps2_read_state_t state;
	ps2_frame_t      shreg;
	logic [3:0]      bit_cnt;
	logic [US_W-1:0] us_cnt;
	logic            timed_out;
	ps2_byte_t       byte_q;
	logic            err_q;

	////////////////////////////////////////
	// Line synchronizers and edge detect
	////////////////////////////////////////

	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			ps2c_sync <= 2'b11;
			ps2d_sync <= 2'b11;
			ps2c_old  <= 1'b1;
		end else begin
			ps2c_sync <= {ps2c_sync[0], ps2c};
			ps2d_sync <= {ps2d_sync[0], ps2d};
			ps2c_old  <= ps2c_sync[1];
		end
	end

	assign fall_edge  = ps2c_old && !ps2c_sync[1];
	assign lines_idle = ps2c_sync[1] && ps2d_sync[1];

	assign shift_en    = fall_edge && enable && (state == st_idle || state == st_read);
	assign timeout_hit = us_tick && us_cnt == US_W'(TIMEOUT_US - 1);
	assign done_idle   = state == st_end && enable && lines_idle && us_tick
		&& us_cnt == US_W'(IDLE_US - 1);

	// Start must be 0, data plus parity odd, stop 1
	assign frame_err = shreg[0] || !(^shreg[9:1]) || !shreg[PS2_FRAME_BITS-1] || timed_out;

	////////////////////////////////////////
	// Frame FSM
	////////////////////////////////////////

	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			state     <= st_idle;
			bit_cnt   <= '0;
			us_cnt    <= '0;
			timed_out <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					us_cnt    <= '0;
					timed_out <= 1'b0;
					if (enable && fall_edge) begin
						bit_cnt <= 4'd1;
						state   <= st_read;
					end
				end
				st_read: begin
					if (!enable) begin
						state <= st_idle;
					end else if (fall_edge && bit_cnt == LAST_BIT) begin
						us_cnt <= '0;
						state  <= st_end;
					end else if (timeout_hit) begin
						timed_out <= 1'b1;
						us_cnt    <= '0;
						state     <= st_end;
					end else begin
						if (fall_edge)
							bit_cnt <= bit_cnt + 4'd1;
						if (us_tick)
							us_cnt <= us_cnt + 1'b1;
					end
				end
				st_end: begin
					if (!enable)
						state <= st_idle;
					else if (done_idle)
						state <= st_hold;
					else if (!lines_idle)
						us_cnt <= '0;
					else if (us_tick)
						us_cnt <= us_cnt + 1'b1;
				end
				// Line is ignored until the arbiter takes the frame
				st_hold: begin
					if (frame.grant)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_main_loop) begin
		if (shift_en)
			shreg <= {ps2d_sync[1], shreg[PS2_FRAME_BITS-1:1]};
		if (done_idle) begin
			byte_q <= shreg[8:1];
			err_q  <= frame_err;
		end
	end

	assign reading          = state != st_idle;
	assign frame.pending    = state == st_hold;
	assign frame.entry_byte = byte_q;
	assign frame.err        = err_q;

	a_pending_held: assert property (@(posedge clk_main_loop) disable iff (!rst_n)
		$fell(frame.pending) |-> $past(frame.grant));

endmodule

// ==== source/ps2_frame_arbiter.sv ====
`timescale 1ns/1ps

module ps2_frame_arbiter (
	input  logic                clk_main_loop,
	input  logic                rst_n,
	ps2_frame_if.arbiter        req0,
	ps2_frame_if.arbiter        req1,
	input  logic                full,
	output logic                wr_en,
	output ps2_pkg::ps2_entry_t wr_entry
);
	import ps2_pkg::*;

	ps2_port_t last_q;
	ps2_port_t sel;
	logic      grant0_q;
	logic      grant1_q;
	logic      any_req;
	logic      can_grant;

	assign any_req = req0.pending || req1.pending;

	// Full lags a write by one cycle and the granted reader still shows
	// pending in that cycle, so no grant right after a write
	assign can_grant = !full && !wr_en;

	// Round robin where the port not served last wins a tie
	always_comb begin
		if (req0.pending && req1.pending)
			sel = ~last_q;
		else if (req1.pending)
			sel = ps2_port_t'(1);
		else
			sel = ps2_port_t'(0);
	end

	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			grant0_q <= 1'b0;
			grant1_q <= 1'b0;
			wr_en    <= 1'b0;
			last_q   <= '0;
		end else begin
			grant0_q <= can_grant && any_req && sel == ps2_port_t'(0);
			grant1_q <= can_grant && any_req && sel == ps2_port_t'(1);
			wr_en    <= can_grant && any_req;
			if (can_grant && any_req)
				last_q <= sel;
		end
	end

	always_ff @(posedge clk_main_loop) begin
		if (can_grant && any_req)
			wr_entry <= sel[0] ? {sel, req1.err, req1.entry_byte}
				: {sel, req0.err, req0.entry_byte};
	end

	assign req0.grant = grant0_q;
	assign req1.grant = grant1_q;

	// A waiting reader keeps its frame steady until granted
	a_req0_steady: assert property (@(posedge clk_main_loop) disable iff (!rst_n)
		req0.pending && !req0.grant |=> req0.pending && $stable({req0.err, req0.entry_byte}));

	a_req1_steady: assert property (@(posedge clk_main_loop) disable iff (!rst_n)
		req1.pending && !req1.grant |=> req1.pending && $stable({req1.err, req1.entry_byte}));

endmodule

// ==== source/ps2_frame_buffer.sv ====
`timescale 1ns/1ps

module ps2_frame_buffer #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                clk_main_loop,
	input  logic                rst_n,
	input  logic                wr_en,
	input  ps2_pkg::ps2_entry_t wr_entry,
	input  logic                rd_en,
	output ps2_pkg::ps2_entry_t rd_entry,
	output logic                empty,
	output logic                full
);
	import ps2_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	ps2_entry_t       mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// Advance with a wrap after the last slot
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_wr = wr_en && !full;
	assign do_rd = rd_en && !empty;

	always_ff @(posedge clk_main_loop) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_rd)
				rd_ptr <= next_ptr(rd_ptr);
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_main_loop) begin
		if (do_wr)
			mem[wr_ptr] <= wr_entry;
	end

	// Fall-through head
	assign rd_entry = mem[rd_ptr];
	assign empty    = count == '0;
	assign full     = count == CNT_W'(FIFO_DEPTH);

	a_no_write_full: assert property (@(posedge clk_main_loop) disable iff (!rst_n)
		!(wr_en && full));

endmodule

// ==== source/ps2_host.sv ====
`timescale 1ns/1ps

module ps2_host #(
	parameter int CLK_PER_US = 125,
	parameter int TIMEOUT_US = 2000,
	parameter int IDLE_US    = 100,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                clk_main_loop,
	input  logic                rst_n,
	input  logic                ps2c0,
	input  logic                ps2d0,
	input  logic                enable0,
	output logic                reading0,
	input  logic                ps2c1,
	input  logic                ps2d1,
	input  logic                enable1,
	output logic                reading1,
	input  logic                rd_en,
	output ps2_pkg::ps2_entry_t rd_entry,
	output logic                empty,
	output logic                full
);
	import ps2_pkg::*;

	logic       us_tick;
	logic       wr_en;
	ps2_entry_t wr_entry;

	ps2_frame_if kbd_if ();
	ps2_frame_if mouse_if ();

	ps2_tick_gen #(.CLK_PER_US(CLK_PER_US)) tick0 (
		.clk_main_loop(clk_main_loop), .rst_n(rst_n), .us_tick(us_tick)
	);

	////////////////////////////////////////
	// Port 0 keyboard, port 1 mouse
	////////////////////////////////////////

	ps2_read #(.TIMEOUT_US(TIMEOUT_US), .IDLE_US(IDLE_US)) rd_kbd (
		.clk_main_loop(clk_main_loop), .rst_n(rst_n), .us_tick(us_tick), .enable(enable0),
		.ps2c(ps2c0), .ps2d(ps2d0), .reading(reading0), .frame(kbd_if.reader)
	);

	ps2_read #(.TIMEOUT_US(TIMEOUT_US), .IDLE_US(IDLE_US)) rd_mouse (
		.clk_main_loop(clk_main_loop), .rst_n(rst_n), .us_tick(us_tick), .enable(enable1),
		.ps2c(ps2c1), .ps2d(ps2d1), .reading(reading1), .frame(mouse_if.reader)
	);

	ps2_frame_arbiter arb0 (
		.clk_main_loop(clk_main_loop), .rst_n(rst_n), .req0(kbd_if.arbiter),
		.req1(mouse_if.arbiter), .full(full), .wr_en(wr_en), .wr_entry(wr_entry)
	);

	ps2_frame_buffer #(.FIFO_DEPTH(FIFO_DEPTH)) buf0 (
		.clk_main_loop(clk_main_loop), .rst_n(rst_n), .wr_en(wr_en), .wr_entry(wr_entry),
		.rd_en(rd_en), .rd_entry(rd_entry), .empty(empty), .full(full)
	);

endmodule

// ==== test/ps2_host_tb.sv ====
`timescale 1ns/1ps

module ps2_host_tb;
	import ps2_pkg::*;

	localparam int US_CYCLES   = 4;
	localparam int WAIT_CYCLES = 3000 * US_CYCLES;

	logic       clk_main_loop;
	logic       rst_n;
	logic       ps2c0;
	logic       ps2d0;
	logic       ps2c1;
	logic       ps2d1;
	logic       enable0;
	logic       enable1;
	logic       reading0;
	logic       reading1;
	logic       rd_en;
	ps2_entry_t rd_entry;
	logic       empty;
	logic       full;

	// Open-collector lines read high unless the device pulls them low
	bit c_low [2];
	bit d_low [2];
	bit seen_read [2];
	int n_pass;
	int n_fail;
	bit test_ok;

	assign ps2c0 = !c_low[0];
	assign ps2d0 = !d_low[0];
	assign ps2c1 = !c_low[1];
	assign ps2d1 = !d_low[1];

	always #4 clk_main_loop = ~clk_main_loop;

	ps2_host #(.CLK_PER_US(US_CYCLES), .TIMEOUT_US(2000), .IDLE_US(100), .FIFO_DEPTH(4)) dut0 (
		.clk_main_loop(clk_main_loop), .rst_n(rst_n),
		.ps2c0(ps2c0), .ps2d0(ps2d0), .enable0(enable0), .reading0(reading0),
		.ps2c1(ps2c1), .ps2d1(ps2d1), .enable1(enable1), .reading1(reading1),
		.rd_en(rd_en), .rd_entry(rd_entry), .empty(empty), .full(full)
	);

	task automatic check_value(input string name, input string what, input int exp, input int act);
		if (exp != act) begin
			$display("CHECK FAILED %s %s: expected %0h, actual %0h", name, what, exp, act);
			test_ok = 1'b0;
		end
	endtask

	////////////////////////////////////////
	// Device side bit-bang
	////////////////////////////////////////

	task automatic send_frame(input int port, input ps2_byte_t data, input string fault);
		ps2_frame_t bits;
		int nbits;
		int half;
		int i;
		// Stop, odd parity, data LSB first, start
		bits = {1'b1, ~^data, data, 1'b0};
		nbits = PS2_FRAME_BITS;
		if (fault == "parity")
			bits[9] = ~bits[9];
		else if (fault == "stop")
			bits[10] = 1'b0;
		else if (fault == "trunc")
			nbits = 6;
		for (i = 0; i < nbits; i++) begin
			half = ((($urandom % 21) + 30) * US_CYCLES) / 2;
			@(negedge clk_main_loop);
			d_low[port] = !bits[i];
			repeat (half) @(negedge clk_main_loop);
			c_low[port] = 1'b1;
			repeat (half) @(negedge clk_main_loop);
			if ((port == 0) ? reading0 : reading1)
				seen_read[port] = 1'b1;
			c_low[port] = 1'b0;
		end
		@(negedge clk_main_loop);
		d_low[port] = 1'b0;
	endtask

	// Take the head once empty falls and pop it with a one-cycle rd_en
	task automatic pop_entry(output ps2_entry_t e, output bit got);
		int t;
		got = 1'b0;
		e = '0;
		for (t = 0; t < WAIT_CYCLES && !got; t++) begin
			@(negedge clk_main_loop);
			if (!empty) begin
				got = 1'b1;
				e = rd_entry;
				rd_en = 1'b1;
			end
		end
		if (got) begin
			@(negedge clk_main_loop);
			rd_en = 1'b0;
		end
	endtask

	task automatic run_test(input string name, input string port_s, input ps2_byte_t data,
			input string fault, input int en, input int exp_err);
		ps2_entry_t e;
		ps2_byte_t b1;
		bit got;
		bit stray;
		int lo;
		int hi;
		int k;
		int p;
		int n_seen [2];
		lo = (port_s == "1") ? 1 : 0;
		hi = (port_s == "0") ? 0 : 1;
		b1 = (port_s == "both") ? ~data : data;
		test_ok = 1'b1;
		stray = 1'b0;
		n_seen = '{0, 0};
		seen_read = '{0, 0};
		@(negedge clk_main_loop);
		if (lo == 0)
			enable0 = en[0];
		if (hi == 1)
			enable1 = en[0];
		fork
			if (lo == 0) send_frame(0, data, fault);
			if (hi == 1) send_frame(1, b1, fault);
		join
		if (en != 0) begin
			for (k = lo; k <= hi; k++) begin
				pop_entry(e, got);
				if (!got) begin
					$display("%s: no entry arrived within the wait window", name);
					test_ok = 1'b0;
				end else begin
					// At most two entries are ever stored in four slots
					check_value(name, "full", 0, full);
					p = e[9];
					n_seen[p]++;
					if (port_s != "both")
						check_value(name, "port", lo, p);
					check_value(name, "err", exp_err, e[8]);
					if (exp_err == 0)
						check_value(name, "byte", p ? b1 : data, e[7:0]);
				end
			end
			if (port_s == "both") begin
				check_value(name, "port 0 entries", 1, n_seen[0]);
				check_value(name, "port 1 entries", 1, n_seen[1]);
			end
		end else begin
			for (k = 0; k < WAIT_CYCLES; k++) begin
				@(negedge clk_main_loop);
				if (!empty)
					stray = 1'b1;
			end
			if (stray) begin
				$display("%s: an entry arrived while the reader was disabled", name);
				test_ok = 1'b0;
			end
			// Drain anything that was stored
			k = 0;
			while (!empty && k < 8) begin
				pop_entry(e, got);
				k++;
			end
			check_value(name, "stored entries", 0, k);
		end
		for (k = lo; k <= hi; k++)
			check_value(name, "reading seen", en, seen_read[k]);
		@(negedge clk_main_loop);
		enable0 = 1'b1;
		enable1 = 1'b1;
		if (test_ok) begin
			n_pass++;
			$display("PASS %s", name);
		end else begin
			n_fail++;
			$display("FAIL %s", name);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		int fd;
		int code;
		int en;
		int exp_err;
		string line;
		string name;
		string port_s;
		string fault;
		ps2_byte_t b;
		clk_main_loop = 1'b0;
		rst_n = 1'b0;
		c_low = '{0, 0};
		d_low = '{0, 0};
		enable0 = 1'b1;
		enable1 = 1'b1;
		rd_en = 1'b0;
		n_pass = 0;
		n_fail = 0;
		void'($urandom(51));
		repeat (5) @(negedge clk_main_loop);
		rst_n = 1'b1;
		fd = $fopen("test/ps2_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file");
			n_fail++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				if (code > 0 && line[0] != "#") begin
					code = $sscanf(line, "%s %s %h %s %d %d", name, port_s, b, fault, en, exp_err);
					if (code == 6)
						run_test(name, port_s, b, fault, en, exp_err);
				end
			end
			$fclose(fd);
		end
		$display("Tests: %0d passed, %0d failed", n_pass, n_fail);
		if (n_fail == 0 && n_pass > 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== ps2_host.f ====
source/ps2_pkg.sv
source/ps2_frame_if.sv
source/ps2_tick_gen.sv
source/ps2_read.sv
source/ps2_frame_arbiter.sv
source/ps2_frame_buffer.sv
source/ps2_host.sv
test/ps2_host_tb.sv

// ==== Bender.yml ====
package:
  name: ps2_host

sources:
  - source/ps2_pkg.sv
  - source/ps2_frame_if.sv
  - source/ps2_tick_gen.sv
  - source/ps2_read.sv
  - source/ps2_frame_arbiter.sv
  - source/ps2_frame_buffer.sv
  - source/ps2_host.sv
  - target: test
    files:
      - test/ps2_host_tb.sv

// ==== test/ps2_stimulus.txt ====
# name port(0, 1 or both) byte(hex) fault(none parity stop trunc) enable exp_err
# With both, port 0 sends the byte and port 1 sends its bitwise inverse
kbd_clean       0    a5 none   1 0
kbd_clean_2     0    3c none   1 0
mouse_clean     1    5a none   1 0
mouse_zero      1    00 none   1 0
kbd_parity      0    f0 parity 1 1
mouse_parity    1    12 parity 1 1
kbd_stop        0    81 stop   1 1
mouse_stop      1    7e stop   1 1
kbd_trunc       0    55 trunc  1 1
mouse_trunc     1    c3 trunc  1 1
both_clean      both 29 none   1 0
both_ff         both ff none   1 0
kbd_disabled    0    1c none   0 0
mouse_disabled  1    e7 none   0 0
kbd_after       0    ff none   1 0
mouse_after     1    80 none   1 0
